//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction format

    typedef logic [5:0] opcode_t;

    // opcode classes by octal range
    typedef enum logic [2:0]
    {
        CLS_ALU     = 3'd0,
        CLS_BRANCH  = 3'd1,
        CLS_JUMP    = 3'd2,
        CLS_SPECIAL = 3'd3,
        CLS_ILLEGAL = 3'd4
    } op_class_t;

    typedef struct packed
    {
        op_class_t  op_class;
        logic [2:0] alu_op;
        logic       trap;
    } exec_ctrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // operation codes for the later stages

    // codes 5 to 7 behave as MEM_NONE
    typedef enum logic [2:0]
    {
        MEM_NONE   = 3'd0,
        MEM_LOAD   = 3'd1,
        MEM_STORE  = 3'd2,
        MEM_IO_IN  = 3'd3,
        MEM_IO_OUT = 3'd4
    } mem_op_t;

    typedef enum logic [1:0]
    {
        WB_REG   = 2'd0,
        WB_MEM   = 2'd1,
        WB_FLAGS = 2'd2,
        WB_NONE  = 2'd3
    } wb_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // control words

    typedef struct packed
    {
        logic       i_req;
        logic       ir_load;
        logic       pc_inc;
        logic       pc_load;
        logic       save_pc;
        logic       vec_load;
        logic       int_ack;
        logic       imm_load;
        logic       issue;
        // only meaningful with issue
        exec_ctrl_t exec;
    } fetch_ctrl_t;

    typedef struct packed
    {
        logic d_req;
        logic d_we;
        logic data_load;
        logic io_load;
        logic hs_out;
        logic busy;
    } mem_ctrl_t;

    typedef struct packed
    {
        logic reg_we;
        logic flag_we;
        logic wb_wait;
    } wb_ctrl_t;

endpackage

//--- hdl/fetch_seq.sv
`timescale 1ns/10ps

module fetch_seq
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  int_pending,
    input  logic                  pc_w,
    input  logic                  i_odv,
    input  ctrl_pkg::exec_ctrl_t  exec_ctrl,
    input  logic                  imm_needed,
    input  logic                  mem_idle,
    input  logic                  wb_idle,
    output ctrl_pkg::fetch_ctrl_t fetch_ctrl
);

    typedef enum logic [3:0]
    {
        F_IDLE,
        F_PC_WR,
        F_INT_SAVE,
        F_INT_VEC,
        F_I_WAIT,
        F_IR_LOAD,
        F_DISPATCH,
        F_IMM_WAIT,
        F_IMM_LOAD
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // state register

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= F_IDLE;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state

    always_comb
    begin
        state_nxt = state;
        case (state)
            F_IDLE:
            begin
                // hold off until write-back has drained
                if (wb_idle)
                begin
                    if (pc_w)
                        state_nxt = F_PC_WR;
                    else if (int_pending)
                        state_nxt = F_INT_SAVE;
                    else
                        state_nxt = F_I_WAIT;
                end
            end
            F_PC_WR:
            begin
                if (int_pending)
                    state_nxt = F_INT_SAVE;
                else
                    state_nxt = F_I_WAIT;
            end
            F_INT_SAVE: state_nxt = F_INT_VEC;
            F_INT_VEC:  state_nxt = F_I_WAIT;
            F_I_WAIT:
            begin
                if (i_odv)
                    state_nxt = F_IR_LOAD;
            end
            F_IR_LOAD:  state_nxt = F_DISPATCH;
            F_DISPATCH:
            begin
                // stall here while the memory stage is busy
                if (mem_idle)
                    state_nxt = imm_needed ? F_IMM_WAIT : F_IDLE;
            end
            F_IMM_WAIT:
            begin
                if (i_odv)
                    state_nxt = F_IMM_LOAD;
            end
            F_IMM_LOAD: state_nxt = F_IDLE;
            default:    state_nxt = F_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs

    always_comb
    begin
        fetch_ctrl = '0;
        case (state)
            F_PC_WR:    fetch_ctrl.pc_load = 1'b1;
            F_INT_SAVE: fetch_ctrl.save_pc = 1'b1;
            F_INT_VEC:
            begin
                fetch_ctrl.vec_load = 1'b1;
                fetch_ctrl.int_ack  = 1'b1;
            end
            F_I_WAIT,
            F_IMM_WAIT: fetch_ctrl.i_req = 1'b1;
            F_IR_LOAD:
            begin
                fetch_ctrl.ir_load = 1'b1;
                fetch_ctrl.pc_inc  = 1'b1;
            end
            F_DISPATCH:
            begin
                fetch_ctrl.issue = mem_idle;
                if (mem_idle)
                    fetch_ctrl.exec = exec_ctrl;
            end
            F_IMM_LOAD:
            begin
                fetch_ctrl.imm_load = 1'b1;
                fetch_ctrl.pc_inc   = 1'b1;
            end
            default:    fetch_ctrl = '0;
        endcase
    end

endmodule

//--- hdl/mem_seq.sv
`timescale 1ns/10ps

module mem_seq
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  logic                d_odv,
    input  logic                hs_in,
    input  logic                d_rdy,
    input  ctrl_pkg::mem_op_t   mem_op,
    input  ctrl_pkg::wb_op_t    wb_op,
    output ctrl_pkg::mem_ctrl_t mem_ctrl,
    output logic                mem_idle,
    output logic                mem_done,
    output ctrl_pkg::wb_op_t    wb_op_q
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_RDY,
        M_LD_REQ,
        M_LD_DATA,
        M_ST_REQ,
        M_IO_REQ,
        M_IO_REL
    } mem_state_t;

    mem_state_t        state;
    mem_state_t        state_nxt;
    ctrl_pkg::mem_op_t op_q;
    logic              start;

    assign start = issue && (state == M_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // operation capture

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            case (mem_op)
                ctrl_pkg::MEM_LOAD,
                ctrl_pkg::MEM_STORE,
                ctrl_pkg::MEM_IO_IN,
                ctrl_pkg::MEM_IO_OUT: op_q <= mem_op;
                default:              op_q <= ctrl_pkg::MEM_NONE;
            endcase
            wb_op_q <= wb_op;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= M_IDLE;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencing

    always_comb
    begin
        state_nxt = state;
        case (state)
            M_IDLE:
            begin
                if (start)
                    state_nxt = M_RDY;
            end
            M_RDY:
            begin
                // nothing starts while write-back waits on memory
                if (d_rdy)
                begin
                    case (op_q)
                        ctrl_pkg::MEM_LOAD:   state_nxt = M_LD_REQ;
                        ctrl_pkg::MEM_STORE:  state_nxt = M_ST_REQ;
                        ctrl_pkg::MEM_IO_IN,
                        ctrl_pkg::MEM_IO_OUT: state_nxt = M_IO_REQ;
                        default:              state_nxt = M_IDLE;
                    endcase
                end
            end
            M_LD_REQ:
            begin
                if (d_odv)
                    state_nxt = M_LD_DATA;
            end
            M_LD_DATA: state_nxt = M_IDLE;
            M_ST_REQ:
            begin
                if (d_odv)
                    state_nxt = M_IDLE;
            end
            // four-phase handshake
            M_IO_REQ:
            begin
                if (hs_in)
                    state_nxt = M_IO_REL;
            end
            M_IO_REL:
            begin
                if (!hs_in)
                    state_nxt = M_IDLE;
            end
            default:   state_nxt = M_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs

    assign mem_idle = (state == M_IDLE);
    assign mem_done = (state != M_IDLE) && (state_nxt == M_IDLE);

    always_comb
    begin
        mem_ctrl      = '0;
        mem_ctrl.busy = (state != M_IDLE);
        case (state)
            M_LD_REQ:  mem_ctrl.d_req = 1'b1;
            M_LD_DATA: mem_ctrl.data_load = 1'b1;
            M_ST_REQ:
            begin
                mem_ctrl.d_req = 1'b1;
                mem_ctrl.d_we  = 1'b1;
            end
            M_IO_REQ:  mem_ctrl.hs_out = 1'b1;
            M_IO_REL:  mem_ctrl.io_load = (op_q == ctrl_pkg::MEM_IO_IN) && !hs_in;
            default:   mem_ctrl.d_req = 1'b0;
        endcase
    end

endmodule

//--- hdl/opcode_decode.sv
`timescale 1ns/10ps

module opcode_decode
(
    input  ctrl_pkg::opcode_t    opcode,
    output ctrl_pkg::exec_ctrl_t exec_ctrl,
    output logic                 imm_needed
);

    ctrl_pkg::op_class_t op_class;

    ////////////////////////////////////////////////////////////////////////////
    // class by octal range of the opcode

    function automatic ctrl_pkg::op_class_t class_of(input ctrl_pkg::opcode_t op);
        ctrl_pkg::op_class_t cls;
        if (op < 6'o40)
            cls = ctrl_pkg::CLS_ALU;
        else if (op <= 6'o47)
            cls = ctrl_pkg::CLS_BRANCH;
        else if (op <= 6'o52)
            cls = ctrl_pkg::CLS_JUMP;
        else if (op <= 6'o55)
            cls = ctrl_pkg::CLS_SPECIAL;
        else
            cls = ctrl_pkg::CLS_ILLEGAL;
        return cls;
    endfunction

    assign op_class = class_of(opcode);

    ////////////////////////////////////////////////////////////////////////////
    // execute control word

    always_comb
    begin
        exec_ctrl          = '0;
        exec_ctrl.op_class = op_class;
        case (op_class)
            ctrl_pkg::CLS_ALU:
            begin
                // bits 3..1 pick the alu function
                exec_ctrl.alu_op = opcode[3:1];
            end
            ctrl_pkg::CLS_ILLEGAL:
            begin
                exec_ctrl.trap = 1'b1;
            end
            default:
            begin
                exec_ctrl.alu_op = 3'd0;
            end
        endcase
    end

    // odd alu opcodes carry an immediate, jumps carry a target word
    always_comb
    begin
        case (op_class)
            ctrl_pkg::CLS_ALU:  imm_needed = opcode[0];
            ctrl_pkg::CLS_JUMP: imm_needed = 1'b1;
            default:            imm_needed = 1'b0;
        endcase
    end

endmodule

//--- hdl/pipe_controller.sv
`timescale 1ns/10ps

module pipe_controller
(
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::opcode_t     opcode,
    input  logic                  int_pending,
    input  logic                  pc_w,
    input  logic                  i_odv,
    input  logic                  d_odv,
    input  logic                  hs_in,
    input  ctrl_pkg::mem_op_t     mem_op,
    input  ctrl_pkg::wb_op_t      wb_op,
    output ctrl_pkg::fetch_ctrl_t fetch_ctrl,
    output ctrl_pkg::mem_ctrl_t   mem_ctrl,
    output ctrl_pkg::wb_ctrl_t    wb_ctrl
);

    ctrl_pkg::exec_ctrl_t exec_ctrl;
    logic                 imm_needed;
    logic                 mem_idle;
    logic                 mem_done;
    ctrl_pkg::wb_op_t     wb_op_q;
    logic                 wb_idle;
    logic                 d_rdy;

    ////////////////////////////////////////////////////////////////////////////
    // fetch and decode

    opcode_decode u_decode
    (
        .opcode     (opcode),
        .exec_ctrl  (exec_ctrl),
        .imm_needed (imm_needed)
    );

    fetch_seq u_fetch
    (
        .clk         (clk),
        .rst         (rst),
        .int_pending (int_pending),
        .pc_w        (pc_w),
        .i_odv       (i_odv),
        .exec_ctrl   (exec_ctrl),
        .imm_needed  (imm_needed),
        .mem_idle    (mem_idle),
        .wb_idle     (wb_idle),
        .fetch_ctrl  (fetch_ctrl)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory and write-back

    mem_seq u_mem
    (
        .clk      (clk),
        .rst      (rst),
        .issue    (fetch_ctrl.issue),
        .d_odv    (d_odv),
        .hs_in    (hs_in),
        .d_rdy    (d_rdy),
        .mem_op   (mem_op),
        .wb_op    (wb_op),
        .mem_ctrl (mem_ctrl),
        .mem_idle (mem_idle),
        .mem_done (mem_done),
        .wb_op_q  (wb_op_q)
    );

    wb_seq u_wb
    (
        .clk      (clk),
        .rst      (rst),
        .mem_done (mem_done),
        .d_odv    (d_odv),
        .wb_op    (wb_op_q),
        .wb_ctrl  (wb_ctrl),
        .wb_idle  (wb_idle),
        .d_rdy    (d_rdy)
    );

endmodule

//--- hdl/wb_seq.sv
`timescale 1ns/10ps

module wb_seq
(
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_done,
    input  logic               d_odv,
    input  ctrl_pkg::wb_op_t   wb_op,
    output ctrl_pkg::wb_ctrl_t wb_ctrl,
    output logic               wb_idle,
    output logic               d_rdy
);

    typedef enum logic [1:0]
    {
        W_IDLE,
        W_REG,
        W_FLAGS,
        W_MEM_WAIT
    } wb_state_t;

    wb_state_t state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= W_IDLE;
        else
        begin
            case (state)
                W_IDLE:
                begin
                    if (mem_done)
                    begin
                        case (wb_op)
                            ctrl_pkg::WB_REG:   state <= W_REG;
                            ctrl_pkg::WB_MEM:   state <= W_MEM_WAIT;
                            ctrl_pkg::WB_FLAGS: state <= W_FLAGS;
                            default:            state <= W_IDLE;
                        endcase
                    end
                end
                // memory result lands in the register file after d_odv
                W_MEM_WAIT:
                begin
                    if (d_odv)
                        state <= W_REG;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    assign wb_ctrl.reg_we  = (state == W_REG);
    assign wb_ctrl.flag_we = (state == W_FLAGS);
    assign wb_ctrl.wb_wait = (state == W_MEM_WAIT);

    assign wb_idle = (state == W_IDLE);
    // memory stage waits until a memory result has been written
    assign d_rdy   = (state != W_MEM_WAIT) && (state != W_REG);

endmodule

//--- pipe_controller.f
hdl/ctrl_pkg.sv
hdl/opcode_decode.sv
hdl/fetch_seq.sv
hdl/mem_seq.sv
hdl/wb_seq.sv
hdl/pipe_controller.sv
testbench/tb_pipe_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pipe_controller \
    -f pipe_controller.f \
    -o tb_pipe_controller

./obj_dir/tb_pipe_controller | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log
then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log
then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- testbench/tb_pipe_controller.sv
`timescale 1ns/10ps

module tb_pipe_controller;

    localparam int N_INSTR     = 200;
    // about 200 instructions at up to 15 cycles each, with margin
    localparam int CYCLE_LIMIT = 4000;

    logic                  clk;
    logic                  rst;
    ctrl_pkg::opcode_t     opcode;
    logic                  int_pending;
    logic                  pc_w;
    logic                  i_odv;
    logic                  d_odv;
    logic                  hs_in;
    ctrl_pkg::mem_op_t     mem_op;
    ctrl_pkg::wb_op_t      wb_op;
    ctrl_pkg::fetch_ctrl_t fetch_ctrl;
    ctrl_pkg::mem_ctrl_t   mem_ctrl;
    ctrl_pkg::wb_ctrl_t    wb_ctrl;

    integer seed           = 87;
    int     mismatch_count = 0;
    int     failure_count  = 0;
    int     cycle_count;
    int     resp_count;
    int     d_wait;
    int     hs_wait;

    // what the memory stage and fetch should be working on
    ctrl_pkg::mem_op_t exp_mem_op;
    ctrl_pkg::wb_op_t  exp_wb_op;
    logic              imm_pending;

    pipe_controller uut
    (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .int_pending (int_pending),
        .pc_w        (pc_w),
        .i_odv       (i_odv),
        .d_odv       (d_odv),
        .hs_in       (hs_in),
        .mem_op      (mem_op),
        .wb_op       (wb_op),
        .fetch_ctrl  (fetch_ctrl),
        .mem_ctrl    (mem_ctrl),
        .wb_ctrl     (wb_ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference rules

    function automatic ctrl_pkg::exec_ctrl_t expected_exec(input ctrl_pkg::opcode_t op);
        ctrl_pkg::exec_ctrl_t e;
        e = '0;
        case (op[5:3])
            3'o0, 3'o1, 3'o2, 3'o3:
            begin
                e.op_class = ctrl_pkg::CLS_ALU;
                e.alu_op   = op[3:1];
            end
            3'o4:    e.op_class = ctrl_pkg::CLS_BRANCH;
            3'o5:
            begin
                if (op[2:0] <= 3'o2)
                    e.op_class = ctrl_pkg::CLS_JUMP;
                else if (op[2:0] <= 3'o5)
                    e.op_class = ctrl_pkg::CLS_SPECIAL;
                else
                begin
                    e.op_class = ctrl_pkg::CLS_ILLEGAL;
                    e.trap     = 1'b1;
                end
            end
            default:
            begin
                e.op_class = ctrl_pkg::CLS_ILLEGAL;
                e.trap     = 1'b1;
            end
        endcase
        return e;
    endfunction

    function automatic logic needs_second_word(input ctrl_pkg::opcode_t op);
        return (!op[5] && op[0]) || (op[5:3] == 3'o5 && op[2:0] <= 3'o2);
    endfunction

    function automatic ctrl_pkg::mem_op_t effective_mem_op(input ctrl_pkg::mem_op_t op);
        ctrl_pkg::mem_op_t m;
        m = op;
        if (op > ctrl_pkg::MEM_IO_OUT)
            m = ctrl_pkg::MEM_NONE;
        return m;
    endfunction

    function automatic ctrl_pkg::wb_ctrl_t expected_wb_start(input ctrl_pkg::wb_op_t op);
        ctrl_pkg::wb_ctrl_t w;
        w = '0;
        case (op)
            ctrl_pkg::WB_REG:   w.reg_we  = 1'b1;
            ctrl_pkg::WB_FLAGS: w.flag_we = 1'b1;
            ctrl_pkg::WB_MEM:   w.wb_wait = 1'b1;
            default:            w = '0;
        endcase
        return w;
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                            input logic [31:0] actual);
        $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        mismatch_count++;
    endfunction

    function automatic void report_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        failure_count++;
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            exp_mem_op  <= ctrl_pkg::MEM_NONE;
            exp_wb_op   <= ctrl_pkg::WB_NONE;
            imm_pending <= 1'b0;
        end
        else if (fetch_ctrl.issue)
        begin
            exp_mem_op  <= effective_mem_op(mem_op);
            exp_wb_op   <= wb_op;
            imm_pending <= needs_second_word(opcode);
        end
        else if (fetch_ctrl.imm_load)
            imm_pending <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reset, fetch and dispatch

    assert property (@(posedge clk) rst |=> fetch_ctrl == '0)
        else report_mismatch("fetch_ctrl", 32'd0, 32'($sampled(fetch_ctrl)));
    assert property (@(posedge clk) rst |=> mem_ctrl == '0)
        else report_mismatch("mem_ctrl", 32'd0, 32'($sampled(mem_ctrl)));
    assert property (@(posedge clk) rst |=> wb_ctrl == '0)
        else report_mismatch("wb_ctrl", 32'd0, 32'($sampled(wb_ctrl)));

    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.i_req && i_odv && !imm_pending |=> fetch_ctrl.ir_load && fetch_ctrl.pc_inc)
        else report_failure("instruction word taken without ir_load and pc_inc");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.i_req && i_odv && imm_pending |=> fetch_ctrl.imm_load && fetch_ctrl.pc_inc)
        else report_failure("second word taken without imm_load and pc_inc");
    assert property (@(posedge clk) disable iff (rst) fetch_ctrl.imm_load |-> imm_pending)
        else report_failure("imm_load for an opcode without a second word");
    assert property (@(posedge clk) disable iff (rst)
        $past(fetch_ctrl.ir_load) && !mem_ctrl.busy |-> fetch_ctrl.issue)
        else report_mismatch("fetch_ctrl.issue", 32'd1, 32'($sampled(fetch_ctrl.issue)));
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.issue |-> fetch_ctrl.exec == expected_exec(opcode))
        else report_mismatch("fetch_ctrl.exec", 32'(expected_exec($sampled(opcode))),
                             32'($sampled(fetch_ctrl.exec)));
    // second word fetch follows issue exactly when the opcode needs one
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.issue |=> fetch_ctrl.i_req == imm_pending)
        else report_mismatch("fetch_ctrl.i_req", 32'($sampled(imm_pending)),
                             32'($sampled(fetch_ctrl.i_req)));

    ////////////////////////////////////////////////////////////////////////////
    // pc write and interrupt entry

    assert property (@(posedge clk) disable iff (rst) fetch_ctrl.pc_load |-> $past(pc_w))
        else report_failure("pc_load without a pc write request");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.pc_load && int_pending |=> fetch_ctrl.save_pc)
        else report_failure("interrupt not entered after pc_load");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.pc_load && !int_pending |=> fetch_ctrl.i_req)
        else report_failure("no instruction request after pc_load");
    assert property (@(posedge clk) disable iff (rst) fetch_ctrl.save_pc |-> int_pending)
        else report_failure("save_pc without a pending interrupt");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.save_pc |=> fetch_ctrl.vec_load && fetch_ctrl.int_ack)
        else report_failure("save_pc not followed by vec_load with int_ack");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.vec_load |-> $past(fetch_ctrl.save_pc))
        else report_failure("vec_load without save_pc in the cycle before");
    assert property (@(posedge clk) disable iff (rst) fetch_ctrl.vec_load |=> fetch_ctrl.i_req)
        else report_failure("no instruction request after interrupt entry");
    assert property (@(posedge clk) disable iff (rst)
        fetch_ctrl.i_req |-> !pc_w && !int_pending)
        else report_failure("instruction fetched while a pc write or interrupt was pending");

    ////////////////////////////////////////////////////////////////////////////
    // memory stage and I/O handshake

    assert property (@(posedge clk) disable iff (rst) wb_ctrl.wb_wait |-> !mem_ctrl.d_req)
        else report_mismatch("mem_ctrl.d_req", 32'd0, 32'($sampled(mem_ctrl.d_req)));
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.d_req |-> (exp_mem_op == ctrl_pkg::MEM_LOAD && !mem_ctrl.d_we) ||
                           (exp_mem_op == ctrl_pkg::MEM_STORE && mem_ctrl.d_we))
        else report_failure("d_req or d_we does not fit the captured memory operation");
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.d_req && mem_ctrl.d_we && !d_odv |=> mem_ctrl.d_req && mem_ctrl.d_we)
        else report_failure("store released d_req or d_we before d_odv");
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.d_req && !mem_ctrl.d_we && d_odv |=> mem_ctrl.data_load)
        else report_mismatch("mem_ctrl.data_load", 32'd1, 32'($sampled(mem_ctrl.data_load)));
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.data_load |-> $past(mem_ctrl.d_req && d_odv))
        else report_failure("data_load without a completed load request");
    assert property (@(posedge clk) disable iff (rst) mem_ctrl.busy |-> !fetch_ctrl.issue)
        else report_failure("issue while the memory stage was busy");

    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.hs_out && !hs_in |=> mem_ctrl.hs_out)
        else report_failure("hs_out dropped before hs_in was seen high");
    assert property (@(posedge clk) disable iff (rst) $fell(mem_ctrl.hs_out) |-> $past(hs_in))
        else report_failure("hs_out fell without hs_in high");
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.io_load |-> !hs_in && $past(hs_in) && exp_mem_op == ctrl_pkg::MEM_IO_IN)
        else report_failure("io_load outside the release of an I/O input");
    assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.busy && !mem_ctrl.hs_out && $fell(hs_in) &&
        exp_mem_op == ctrl_pkg::MEM_IO_IN |-> mem_ctrl.io_load)
        else report_mismatch("mem_ctrl.io_load", 32'd1, 32'($sampled(mem_ctrl.io_load)));

    ////////////////////////////////////////////////////////////////////////////
    // write-back

    assert property (@(posedge clk) disable iff (rst)
        $fell(mem_ctrl.busy) |-> wb_ctrl == expected_wb_start(exp_wb_op))
        else report_mismatch("wb_ctrl", 32'(expected_wb_start($sampled(exp_wb_op))),
                             32'($sampled(wb_ctrl)));
    assert property (@(posedge clk) disable iff (rst)
        wb_ctrl.wb_wait && !d_odv |=> wb_ctrl.wb_wait)
        else report_failure("wb_wait released before d_odv");
    assert property (@(posedge clk) disable iff (rst) wb_ctrl.wb_wait && d_odv |=> wb_ctrl.reg_we)
        else report_mismatch("wb_ctrl.reg_we", 32'd1, 32'($sampled(wb_ctrl.reg_we)));
    assert property (@(posedge clk) disable iff (rst)
        wb_ctrl.reg_we || wb_ctrl.flag_we |=> wb_ctrl == '0)
        else report_failure("register or flag write lasted more than one cycle");

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_fetch_request;
        while (!fetch_ctrl.i_req)
        begin
            step();
            if (fetch_ctrl.pc_load)
                pc_w = 1'b0;
            if (fetch_ctrl.int_ack)
                int_pending = 1'b0;
        end
    endtask

    task automatic answer_fetch_request(input logic [1:0] delay);
        repeat (delay) step();
        i_odv = 1'b1;
        step();
        i_odv = 1'b0;
    endtask

    task automatic run_instruction;
        logic [31:0] rnd;
        rnd         = $random(seed);
        opcode      = rnd[5:0];
        mem_op      = ctrl_pkg::mem_op_t'(rnd[8:6]);
        wb_op       = ctrl_pkg::wb_op_t'(rnd[10:9]);
        pc_w        = (rnd[13:11] == 3'd0);
        int_pending = (rnd[16:14] == 3'd0);
        wait_fetch_request();
        answer_fetch_request(rnd[18:17]);
        while (!fetch_ctrl.issue)
            step();
        // memory stage samples mem_op and wb_op on this edge
        step();
        if (needs_second_word(opcode))
        begin
            answer_fetch_request(rnd[20:19]);
            while (!fetch_ctrl.imm_load)
                step();
            step();
        end
    endtask

    // data and I/O responses with delays cycling through 0, 3, 2, 1
    initial
    begin
        d_odv      = 1'b0;
        hs_in      = 1'b0;
        resp_count = 0;
        d_wait     = 0;
        hs_wait    = 0;
        forever
        begin
            step();
            d_odv = 1'b0;
            if (!rst && (mem_ctrl.d_req || wb_ctrl.wb_wait))
            begin
                if (d_wait == 0)
                begin
                    d_odv      = 1'b1;
                    resp_count = resp_count + 1;
                    d_wait     = (resp_count * 3) % 4;
                end
                else
                    d_wait = d_wait - 1;
            end
            if (!rst && (mem_ctrl.hs_out != hs_in))
            begin
                if (hs_wait == 0)
                begin
                    hs_in      = mem_ctrl.hs_out;
                    resp_count = resp_count + 1;
                    hs_wait    = (resp_count * 3) % 4;
                end
                else
                    hs_wait = hs_wait - 1;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        rst         = 1'b1;
        opcode      = '0;
        int_pending = 1'b0;
        pc_w        = 1'b0;
        i_odv       = 1'b0;
        mem_op      = ctrl_pkg::MEM_NONE;
        wb_op       = ctrl_pkg::WB_NONE;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (N_INSTR) run_instruction();
        // drain memory and write-back
        while (mem_ctrl.busy || wb_ctrl != '0)
            step();
        repeat (4) step();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
